// File: design/accessSplitter.sv
`timescale 1ns/1ns
`include "m68kBridge_cfg.svh"

module accessSplitter (
	input logic   clk68k,
	input logic   rst,
	busReqIf.sink req,
	beatIf.source beat
);

	// Halves still owed to the sequencer with the high half sent first
	logic needHigh;
	logic needLow;
	logic writeQ;
	logic lowHalf;
	m68kBridgePkg::axiAddrT addrQ;
	m68kBridgePkg::longWordT wdataQ;
	m68kBridgePkg::byteStrobeT strbQ;

	assign req.ready = !needHigh && !needLow;
	assign lowHalf = !needHigh;

	assign beat.valid = needHigh || needLow;
	assign beat.lowHalf = lowHalf;
	assign beat.write = writeQ;
	assign beat.last = !(needHigh && needLow);
	// Bits 31:16 sit at the even word address of the big-endian bus
	assign beat.addr = {addrQ[`M68K_ADDR_BITS-1:2], lowHalf};
	assign beat.data = lowHalf ? wdataQ[`BUS_DATA_BITS-1:0]
		: wdataQ[`AXI_DATA_BITS-1:`BUS_DATA_BITS];
	// Reads always fetch the whole word
	assign beat.upper = writeQ ? (lowHalf ? strbQ[1] : strbQ[3]) : 1'b1;
	assign beat.lower = writeQ ? (lowHalf ? strbQ[0] : strbQ[2]) : 1'b1;

	always_ff @(posedge clk68k)
	begin
		if (rst)
		begin
			needHigh <= 1'b0;
			needLow <= 1'b0;
		end
		else if (req.valid && req.ready)
		begin
			// An empty write still costs one strobeless beat on the high half
			needHigh <= !req.write || (|req.strb[3:2]) || !(|req.strb);
			needLow <= !req.write || (|req.strb[1:0]);
		end
		else if (beat.valid && beat.ready)
		begin
			if (needHigh)
				needHigh <= 1'b0;
			else
				needLow <= 1'b0;
		end
	end

	always_ff @(posedge clk68k)
	begin
		if (req.valid && req.ready)
		begin
			addrQ <= req.addr;
			wdataQ <= req.wdata;
			strbQ <= req.strb;
			writeQ <= req.write;
		end
	end

endmodule

// File: design/axiLiteFrontend.sv
`timescale 1ns/1ns

module axiLiteFrontend (
	input  logic                      clk68k,
	input  logic                      rst,
	input  m68kBridgePkg::axiAddrT    awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  m68kBridgePkg::longWordT   wdata,
	input  m68kBridgePkg::byteStrobeT wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output m68kBridgePkg::respT       bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  m68kBridgePkg::axiAddrT    araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output m68kBridgePkg::longWordT   rdata,
	output m68kBridgePkg::respT       rresp,
	output logic                      rvalid,
	input  logic                      rready,
	input  logic                      respValid,
	input  m68kBridgePkg::longWordT   respData,
	input  logic                      respErr,
	busReqIf.source                   req
);

	// Rises on the first cycle after reset
	logic live;
	// Open from address accept until the response handshake
	logic openTxn;
	logic isWrite;
	logic reqValid;
	logic acceptWrite;
	logic acceptRead;
	m68kBridgePkg::axiAddrT addrQ;
	m68kBridgePkg::longWordT wdataQ;
	m68kBridgePkg::byteStrobeT strbQ;
	m68kBridgePkg::respT respCode;

	// AW and W only complete as a pair
	assign awready = live && !openTxn && wvalid;
	assign wready = live && !openTxn && awvalid;
	// A write arriving in the same cycle takes priority
	assign arready = live && !openTxn && !(awvalid && wvalid);

	assign acceptWrite = awvalid && awready;
	assign acceptRead = arvalid && arready;
	assign respCode = respErr ? m68kBridgePkg::respSlvErr : m68kBridgePkg::respOkay;

	assign req.valid = reqValid;
	assign req.addr = addrQ;
	assign req.wdata = wdataQ;
	assign req.strb = strbQ;
	assign req.write = isWrite;

	always_ff @(posedge clk68k)
	begin
		if (rst)
		begin
			live <= 1'b0;
			openTxn <= 1'b0;
			isWrite <= 1'b0;
			reqValid <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			live <= 1'b1;
			if (acceptWrite || acceptRead)
			begin
				openTxn <= 1'b1;
				isWrite <= acceptWrite;
				reqValid <= 1'b1;
			end
			else if (reqValid && req.ready)
				reqValid <= 1'b0;

			// Sequencer result turns into the matching AXI response
			if (respValid && isWrite)
				bvalid <= 1'b1;
			else if (bvalid && bready)
				bvalid <= 1'b0;
			if (respValid && !isWrite)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;

			if ((bvalid && bready) || (rvalid && rready))
				openTxn <= 1'b0;
		end
	end

	always_ff @(posedge clk68k)
	begin
		if (acceptWrite)
		begin
			addrQ <= awaddr;
			wdataQ <= wdata;
			strbQ <= wstrb;
		end
		else if (acceptRead)
			addrQ <= araddr;

		if (respValid)
		begin
			bresp <= respCode;
			rresp <= respCode;
			rdata <= respData;
		end
	end

endmodule

// File: design/beatIf.sv
`timescale 1ns/1ns

interface beatIf;

	logic valid;
	logic ready;
	m68kBridgePkg::busAddrT addr;
	m68kBridgePkg::busWordT data;
	// Active high versions of UDS and LDS
	logic upper;
	logic lower;
	logic write;
	logic last;
	// Beat holds bits 15:0 of the longword
	logic lowHalf;

	modport source
	(
		output valid, addr, data, upper, lower, write, last, lowHalf,
		input ready
	);

	modport sink
	(
		input valid, addr, data, upper, lower, write, last, lowHalf,
		output ready
	);

endinterface

// File: design/busReqIf.sv
`timescale 1ns/1ns

interface busReqIf;

	logic valid;
	logic ready;
	m68kBridgePkg::axiAddrT addr;
	m68kBridgePkg::longWordT wdata;
	m68kBridgePkg::byteStrobeT strb;
	// High for a write access, low for a read
	logic write;

	modport source
	(
		output valid, addr, wdata, strb, write,
		input ready
	);

	modport sink
	(
		input valid, addr, wdata, strb, write,
		output ready
	);

endinterface

// File: design/m68kBridge.sv
`timescale 1ns/1ns

module m68kBridge (
	input  logic                      clk68k,
	input  logic                      rst,
	input  m68kBridgePkg::axiAddrT    awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  m68kBridgePkg::longWordT   wdata,
	input  m68kBridgePkg::byteStrobeT wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output m68kBridgePkg::respT       bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  m68kBridgePkg::axiAddrT    araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output m68kBridgePkg::longWordT   rdata,
	output m68kBridgePkg::respT       rresp,
	output logic                      rvalid,
	input  logic                      rready,
	output m68kBridgePkg::busAddrT    m68kAddr,
	output m68kBridgePkg::busWordT    m68kDataOut,
	input  m68kBridgePkg::busWordT    m68kDataIn,
	output logic                      m68kDataOe,
	output logic                      nAs,
	output logic                      nUds,
	output logic                      nLds,
	output logic                      rw,
	input  logic                      nDtack
);

	logic respValid;
	m68kBridgePkg::longWordT respData;
	logic respErr;

	busReqIf reqBus ();
	beatIf beatBus ();

	axiLiteFrontend frontend (
		.clk68k(clk68k),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.respValid(respValid),
		.respData(respData),
		.respErr(respErr),
		.req(reqBus.source)
	);

	accessSplitter splitter (
		.clk68k(clk68k),
		.rst(rst),
		.req(reqBus.sink),
		.beat(beatBus.source)
	);

	m68kBusSequencer sequencer (
		.clk68k(clk68k),
		.rst(rst),
		.beat(beatBus.sink),
		.m68kAddr(m68kAddr),
		.m68kDataOut(m68kDataOut),
		.m68kDataIn(m68kDataIn),
		.m68kDataOe(m68kDataOe),
		.nAs(nAs),
		.nUds(nUds),
		.nLds(nLds),
		.rw(rw),
		.nDtack(nDtack),
		.respValid(respValid),
		.respData(respData),
		.respErr(respErr)
	);

endmodule

// File: design/m68kBridgePkg.sv
`include "m68kBridge_cfg.svh"

package m68kBridgePkg;

	// Byte address as seen on the AXI side
	typedef logic [`M68K_ADDR_BITS-1:0] axiAddrT;

	typedef logic [`AXI_DATA_BITS-1:0] longWordT;
	typedef logic [`BUS_DATA_BITS-1:0] busWordT;
	typedef logic [`AXI_DATA_BITS/8-1:0] byteStrobeT;

	// Word address on the 68k pins where the data strobes stand in for A0
	typedef logic [`M68K_ADDR_BITS-1:1] busAddrT;

	typedef logic [1:0] respT;

	localparam respT respOkay = 2'b00;
	localparam respT respSlvErr = 2'b10;

	// Address strobe cycle of the bus sequencer
	typedef enum logic [1:0]
	{
		IDLE,
		ASSERT,
		WAIT_ACK,
		RELEASE
	} seqStateT;

endpackage

// File: design/m68kBridge_cfg.svh
`ifndef M68KBRIDGE_CFG_SVH
`define M68KBRIDGE_CFG_SVH

// External 68k byte address width
`define M68K_ADDR_BITS 24

// AXI4-Lite side data width
`define AXI_DATA_BITS 32

// 68k data bus width
`define BUS_DATA_BITS 16

// Cycles spent waiting for DTACK before the beat is flagged as a bus error
`define DTACK_TIMEOUT 16

`endif

// File: design/m68kBusSequencer.sv
`timescale 1ns/1ns
`include "m68kBridge_cfg.svh"

module m68kBusSequencer (
	input  logic                    clk68k,
	input  logic                    rst,
	beatIf.sink                     beat,
	output m68kBridgePkg::busAddrT  m68kAddr,
	output m68kBridgePkg::busWordT  m68kDataOut,
	input  m68kBridgePkg::busWordT  m68kDataIn,
	output logic                    m68kDataOe,
	output logic                    nAs,
	output logic                    nUds,
	output logic                    nLds,
	output logic                    rw,
	input  logic                    nDtack,
	output logic                    respValid,
	output m68kBridgePkg::longWordT respData,
	output logic                    respErr
);

	localparam int timeoutBits = $clog2(`DTACK_TIMEOUT);
	localparam logic [timeoutBits-1:0] timeoutLast = timeoutBits'(`DTACK_TIMEOUT - 1);

	m68kBridgePkg::seqStateT state;
	logic [timeoutBits-1:0] waitCnt;
	logic upperQ;
	logic lowerQ;
	logic writeQ;
	logic lastQ;
	logic lowHalfQ;
	// Sticky over both beats of a longword
	logic errAcc;
	logic inCycle;
	logic strobePhase;

	assign inCycle = (state != m68kBridgePkg::IDLE);
	assign strobePhase = (state == m68kBridgePkg::ASSERT) || (state == m68kBridgePkg::WAIT_ACK);

	assign beat.ready = (state == m68kBridgePkg::IDLE);
	assign nAs = !(state == m68kBridgePkg::WAIT_ACK);
	// Data strobes lead AS by the ASSERT setup cycle
	assign nUds = !(upperQ && strobePhase);
	assign nLds = !(lowerQ && strobePhase);
	assign rw = !(writeQ && inCycle);
	assign m68kDataOe = writeQ && (upperQ || lowerQ) && inCycle;

	assign respValid = (state == m68kBridgePkg::RELEASE) && lastQ;
	assign respErr = errAcc;

	always_ff @(posedge clk68k)
	begin
		if (rst)
		begin
			state <= m68kBridgePkg::IDLE;
			waitCnt <= '0;
			upperQ <= 1'b0;
			lowerQ <= 1'b0;
			writeQ <= 1'b0;
			lastQ <= 1'b0;
			errAcc <= 1'b0;
		end
		else
		begin
			unique case (state)
				m68kBridgePkg::IDLE:
				begin
					if (beat.valid)
					begin
						upperQ <= beat.upper;
						lowerQ <= beat.lower;
						writeQ <= beat.write;
						lastQ <= beat.last;
						// No strobes means nothing to put on the bus
						if (beat.upper || beat.lower)
							state <= m68kBridgePkg::ASSERT;
						else
							state <= m68kBridgePkg::RELEASE;
					end
				end
				m68kBridgePkg::ASSERT:
				begin
					waitCnt <= '0;
					state <= m68kBridgePkg::WAIT_ACK;
				end
				m68kBridgePkg::WAIT_ACK:
				begin
					waitCnt <= waitCnt + 1'b1;
					if (!nDtack)
						state <= m68kBridgePkg::RELEASE;
					else if (waitCnt == timeoutLast)
					begin
						errAcc <= 1'b1;
						state <= m68kBridgePkg::RELEASE;
					end
				end
				m68kBridgePkg::RELEASE:
				begin
					upperQ <= 1'b0;
					lowerQ <= 1'b0;
					writeQ <= 1'b0;
					// Error has been handed to the front end with respValid
					if (lastQ)
						errAcc <= 1'b0;
					state <= m68kBridgePkg::IDLE;
				end
				default:
					state <= m68kBridgePkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk68k)
	begin
		if (beat.valid && beat.ready)
		begin
			m68kAddr <= beat.addr;
			m68kDataOut <= beat.data;
			lowHalfQ <= beat.lowHalf;
		end

		// Read halves land in their own slot of the longword
		if (state == m68kBridgePkg::WAIT_ACK && !nDtack)
		begin
			if (lowHalfQ)
				respData[`BUS_DATA_BITS-1:0] <= m68kDataIn;
			else
				respData[`AXI_DATA_BITS-1:`BUS_DATA_BITS] <= m68kDataIn;
		end
	end

endmodule

// File: m68kBridge.f
+incdir+design
design/m68kBridgePkg.sv
design/busReqIf.sv
design/beatIf.sv
design/axiLiteFrontend.sv
design/accessSplitter.sv
design/m68kBusSequencer.sv
design/m68kBridge.sv
verification/m68kBridge_properties.sv
verification/m68kBridgeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the m68kBridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module m68kBridgeTb -f m68kBridge.f -o m68kBridgeSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/m68kBridgeSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qxF ">>> PASS" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: verification/m68kBridgeTb.sv
`timescale 1ns/1ns

module m68kBridgeTb;

	localparam m68kBridgePkg::respT respOkay = 2'b00;
	localparam m68kBridgePkg::respT respSlvErr = 2'b10;
	// Slave model never acknowledges from here up
	localparam logic [23:0] unmappedBase = 24'hF00000;
	localparam int waitLimit = 400;
	localparam int randomOps = 60;

	typedef struct {
		string name;
		bit isWrite;
		logic [23:0] addr;
		m68kBridgePkg::longWordT data;
		logic [3:0] strb;
		m68kBridgePkg::longWordT expData;
		m68kBridgePkg::respT expResp;
	} stepT;

	logic clk68k;
	logic rst;
	logic [23:0] awaddr;
	logic awvalid;
	logic awready;
	m68kBridgePkg::longWordT wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	m68kBridgePkg::respT bresp;
	logic bvalid;
	logic bready;
	logic [23:0] araddr;
	logic arvalid;
	logic arready;
	m68kBridgePkg::longWordT rdata;
	m68kBridgePkg::respT rresp;
	logic rvalid;
	logic rready;
	logic [23:1] m68kAddr;
	logic [15:0] m68kDataOut;
	logic [15:0] m68kDataIn = 16'h0000;
	logic m68kDataOe;
	logic nAs;
	logic nUds;
	logic nLds;
	logic rw;
	logic nDtack = 1'b1;

	logic [15:0] mem [1024];
	logic [15:0] shadow [1024];
	logic [1:0] waitLeft;
	stepT steps [$];
	// Kind of the AXI access in flight, as the slave model expects it
	bit expectWrite;

	m68kBridge dut_i (.*);

	initial
	begin
		clk68k = 1'b0;
		forever
			#50 clk68k = ~clk68k;
	end

	function automatic logic [15:0] fillWord(input logic [9:0] index);
		return 16'({6'd0, index} * 16'h9E37) ^ 16'h5AA5;
	endfunction

	// 68k slave memory with random wait states and DTACK held until AS rises
	always @(posedge clk68k)
	begin
		if (rst)
		begin
			for (int i = 0; i < 1024; i++)
				mem[i] <= fillWord(10'(i));
		end
		if (rst || nAs)
		begin
			nDtack <= 1'b1;
			waitLeft <= 2'($urandom % 4);
		end
		else if (nDtack)
		begin
			if (waitLeft != 2'd0)
				waitLeft <= waitLeft - 2'd1;
			else if ({m68kAddr, 1'b0} < unmappedBase)
			begin
				nDtack <= 1'b0;
				checkValue("m68kDataOe", 32'(expectWrite), 32'(m68kDataOe));
				if (rw)
					m68kDataIn <= mem[m68kAddr[10:1]];
				else
				begin
					if (!nUds)
						mem[m68kAddr[10:1]][15:8] <= m68kDataOut[15:8];
					if (!nLds)
						mem[m68kAddr[10:1]][7:0] <= m68kDataOut[7:0];
				end
			end
		end
	end

	task automatic failTimeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display(">>> FAIL");
		$fatal(1, "no progress on the AXI bus");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// Strobes 3 and 2 go to the word at A and strobes 1 and 0 to A+2
	function automatic void shadowWrite(input logic [23:0] addr,
		input m68kBridgePkg::longWordT data, input logic [3:0] strb);
		logic [9:0] idx;
		idx = addr[10:1];
		if (strb[3])
			shadow[idx][15:8] = data[31:24];
		if (strb[2])
			shadow[idx][7:0] = data[23:16];
		if (strb[1])
			shadow[10'(idx + 10'd1)][15:8] = data[15:8];
		if (strb[0])
			shadow[10'(idx + 10'd1)][7:0] = data[7:0];
	endfunction

	task automatic axiWrite(input logic [23:0] addr, input m68kBridgePkg::longWordT data,
		input logic [3:0] strb, output m68kBridgePkg::respT resp);
		int cycles;
		expectWrite = 1'b1;
		awaddr <= addr;
		wdata <= data;
		wstrb <= strb;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		cycles = 0;
		do
		begin
			@(posedge clk68k);
			cycles++;
			if (cycles > waitLimit)
				failTimeout("awready and wready");
		end
		while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		// bready toggles randomly to stretch the response
		cycles = 0;
		do
		begin
			bready <= 1'($urandom % 2);
			@(posedge clk68k);
			cycles++;
			if (cycles > waitLimit)
				failTimeout("the write response");
		end
		while (!(bvalid && bready));
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [23:0] addr, output m68kBridgePkg::longWordT data,
		output m68kBridgePkg::respT resp);
		int cycles;
		expectWrite = 1'b0;
		araddr <= addr;
		arvalid <= 1'b1;
		cycles = 0;
		do
		begin
			@(posedge clk68k);
			cycles++;
			if (cycles > waitLimit)
				failTimeout("arready");
		end
		while (!arready);
		arvalid <= 1'b0;
		cycles = 0;
		do
		begin
			rready <= 1'($urandom % 2);
			@(posedge clk68k);
			cycles++;
			if (cycles > waitLimit)
				failTimeout("the read response");
		end
		while (!(rvalid && rready));
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	task automatic addStep(input string name, input bit isWrite, input logic [23:0] addr,
		input m68kBridgePkg::longWordT data, input logic [3:0] strb,
		input m68kBridgePkg::longWordT expData, input m68kBridgePkg::respT expResp);
		stepT s;
		s.name = name;
		s.isWrite = isWrite;
		s.addr = addr;
		s.data = data;
		s.strb = strb;
		s.expData = expData;
		s.expResp = expResp;
		steps.push_back(s);
	endtask

	initial
	begin
		m68kBridgePkg::longWordT rd;
		m68kBridgePkg::respT resp;
		logic [23:0] addr;
		m68kBridgePkg::longWordT data;
		logic [3:0] strb;
		logic [9:0] idx;

		void'($urandom(32'h6ff2_3e6f));
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		for (int i = 0; i < 1024; i++)
			shadow[i] = fillWord(10'(i));

		repeat (4) @(posedge clk68k);
		rst <= 1'b0;

		addStep("fullWrite", 1'b1, 24'h000100, 32'h12345678, 4'b1111, 32'h0, respOkay);
		addStep("fullRead", 1'b0, 24'h000100, 32'h0, 4'b0000, 32'h12345678, respOkay);
		addStep("byte2Write", 1'b1, 24'h000100, 32'hAABBCCDD, 4'b0100, 32'h0, respOkay);
		addStep("byte0Write", 1'b1, 24'h000100, 32'hAABBCCDD, 4'b0001, 32'h0, respOkay);
		addStep("mergedRead", 1'b0, 24'h000100, 32'h0, 4'b0000, 32'h12BB56DD, respOkay);
		addStep("emptyWrite", 1'b1, 24'h000100, 32'hFFFFFFFF, 4'b0000, 32'h0, respOkay);
		addStep("unchangedRead", 1'b0, 24'h000100, 32'h0, 4'b0000, 32'h12BB56DD, respOkay);
		addStep("badRead", 1'b0, 24'hF00000, 32'h0, 4'b0000, 32'h0, respSlvErr);
		addStep("badWrite", 1'b1, 24'hF00010, 32'h55AA55AA, 4'b1111, 32'h0, respSlvErr);
		addStep("recoverWrite", 1'b1, 24'h000104, 32'hCAFEF00D, 4'b1111, 32'h0, respOkay);
		addStep("recoverRead", 1'b0, 24'h000104, 32'h0, 4'b0000, 32'hCAFEF00D, respOkay);

		foreach (steps[i])
		begin
			if (steps[i].isWrite)
			begin
				axiWrite(steps[i].addr, steps[i].data, steps[i].strb, resp);
				if (steps[i].addr < unmappedBase)
					shadowWrite(steps[i].addr, steps[i].data, steps[i].strb);
			end
			else
			begin
				axiRead(steps[i].addr, rd, resp);
				if (steps[i].expResp == respOkay)
					checkValue($sformatf("%s data", steps[i].name), steps[i].expData, rd);
			end
			checkValue($sformatf("%s resp", steps[i].name), 32'(steps[i].expResp),
				32'(resp));
		end

		// High half lives at A and low half at A+2
		checkValue("memHighHalf", 32'h0000CAFE, 32'(mem[10'h082]));
		checkValue("memLowHalf", 32'h0000F00D, 32'(mem[10'h083]));

		for (int n = 0; n < randomOps; n++)
		begin
			addr = 24'h0000F0 + 24'(($urandom % 32) * 4);
			idx = addr[10:1];
			if ($urandom % 2 == 1)
			begin
				data = $urandom;
				strb = 4'($urandom);
				axiWrite(addr, data, strb, resp);
				shadowWrite(addr, data, strb);
				checkValue($sformatf("random %0d write resp", n), 32'(respOkay), 32'(resp));
			end
			else
			begin
				axiRead(addr, rd, resp);
				checkValue($sformatf("random %0d read resp", n), 32'(respOkay), 32'(resp));
				checkValue($sformatf("random %0d read data", n),
					{shadow[idx], shadow[10'(idx + 10'd1)]}, rd);
			end
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: verification/m68kBridge_properties.sv
`timescale 1ns/1ns

module m68kBridgeProperties (
	input logic                   clk68k,
	input logic                   rst,
	input m68kBridgePkg::busAddrT m68kAddr,
	input logic                   nAs,
	input logic                   nUds,
	input logic                   nLds,
	input logic                   bvalid,
	input logic                   bready
);

	// Data strobes may lead AS only by the one setup cycle
	strobeInsideAs: assert property (@(posedge clk68k) disable iff (rst)
		(!nUds || !nLds) && nAs |=> !nAs)
		else $error("data strobe active without a following address strobe");

	addrStable: assert property (@(posedge clk68k) disable iff (rst)
		!nAs |=> nAs || $stable(m68kAddr))
		else $error("bus address changed while the address strobe was low");

	// Write response stays up until the master takes it
	bvalidHold: assert property (@(posedge clk68k) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

endmodule

bind m68kBridge m68kBridgeProperties propsI (
	.clk68k(clk68k),
	.rst(rst),
	.m68kAddr(m68kAddr),
	.nAs(nAs),
	.nUds(nUds),
	.nLds(nLds),
	.bvalid(bvalid),
	.bready(bready)
);
